// File: list.f
+incdir+test
hw/lsq_pkg.sv
hw/store_buffer.sv
hw/store_pair.sv
hw/store_lane.sv
hw/store_drain.sv
test/store_drain_tb.sv

// File: Makefile
TOP = store_drain_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing -f list.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: test/store_model.svh
`ifndef STORE_MODEL_SVH
`define STORE_MODEL_SVH

// next state of the stimulus generator
function automatic logic [31:0] lcg_step(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// expected cache write for one store built one byte at a time
function automatic cache_wr_t expected_write(input store_t s);
  cache_wr_t  w;
  logic [7:0] b;
  int         off;
  int         nbytes;
  int         last;
  int         pos;
  off          = int'(s.addr[1:0]);
  nbytes       = 1 << int'(s.size);
  last         = off + nbytes - 1;
  w.addr       = s.addr;
  w.start_bank = s.addr[4:2];
  // wraps past bank 7
  w.end_bank   = bank_t'(int'(s.addr[4:2]) + last / 4);
  w.bgn_ben    = '0;
  w.end_ben    = '0;
  w.data       = '0;
  for (int k = 0; k < 8; k++) begin
    pos    = off + k;
    b      = 8'(s.data >> (8 * k));
    w.data = w.data | (line_data_t'(b) << (8 * pos));
    // enables only for the bytes the size covers
    if (k < nbytes) begin
      if (pos < 4) begin
        w.bgn_ben = w.bgn_ben | ben_t'(1 << pos);
      end
      // bytes of the last bank touched
      if (pos / 4 == last / 4) begin
        w.end_ben = w.end_ben | ben_t'(1 << (pos % 4));
      end
    end
  end
  return w;
endfunction

task automatic check_value(input logic [127:0] got, input logic [127:0] want, input string what);
  if (got !== want) begin
    mismatches++;
    $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, want);
  end
endtask

`endif

// File: test/store_drain_tb.sv
`timescale 1ns/100ps

module store_drain_tb import lsq_pkg::*; ();

  localparam int NUM_STORES = 300;
  localparam int TIMEOUT    = 40 * NUM_STORES + 100;

  logic         clk = 1'b0;
  logic         arst_n = 1'b0;
  logic         st_req = 1'b0;
  logic         st_ack;
  store_t       st_in = '0;
  logic         st_stall = 1'b0;
  cache_wr_t    st0_wr;
  logic         st0_en;
  cache_wr_t    st1_wr;
  logic         st1_en;

  // scoreboard of accepted stores, oldest first
  store_t       exp_q[$];
  store_t       new_store;
  store_t       first;
  store_t       second;
  logic         got0;
  logic         got1;
  logic [31:0]  rng = 32'hbe93_4778;
  int           mismatches = 0;
  int           other_errors = 0;
  int           sent = 0;
  int           delivered = 0;
  int           cycles = 0;
  int           gap = 0;
  int           stall_left = 0;
  logic         prev_stall = 1'b0;
  logic         prev_req = 1'b0;
  logic         prev_ack = 1'b0;
  logic [122:0] prev_out0 = '0;
  logic [122:0] prev_out1 = '0;

  `include "store_model.svh"

  store_drain #(
    .BUF_DEPTH(4)
  ) dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .st_req  (st_req),
    .st_ack  (st_ack),
    .st_in   (st_in),
    .st_stall(st_stall),
    .st0_wr  (st0_wr),
    .st0_en  (st0_en),
    .st1_wr  (st1_wr),
    .st1_en  (st1_en)
  );

  always #4 clk = ~clk;

  task automatic build_store(output store_t s);
    rng           = lcg_step(rng);
    s.addr        = rng[31:20];
    s.size        = rng[19:18];
    rng           = lcg_step(rng);
    s.data[63:32] = rng;
    rng           = lcg_step(rng);
    s.data[31:0]  = rng;
    // every eighth store is 8 bytes at bank 7 and wraps to bank 0
    if (sent % 8 == 5) begin
      s.addr[4:2] = 3'd7;
      s.size      = 2'd3;
    end
  endtask

  task automatic compare_write(input int lane, input cache_wr_t got, input store_t st);
    cache_wr_t want;
    want = expected_write(st);
    check_value(128'(got.addr), 128'(want.addr), $sformatf("lane %0d addr", lane));
    check_value(128'(got.start_bank), 128'(want.start_bank),
                $sformatf("lane %0d start_bank", lane));
    check_value(128'(got.end_bank), 128'(want.end_bank), $sformatf("lane %0d end_bank", lane));
    check_value(128'(got.bgn_ben), 128'(want.bgn_ben), $sformatf("lane %0d bgn_ben", lane));
    check_value(128'(got.end_ben), 128'(want.end_ben), $sformatf("lane %0d end_ben", lane));
    check_value(128'(got.data), 128'(want.data), $sformatf("lane %0d line data", lane));
  endtask

  task automatic take_delivery(input int lane, input cache_wr_t got, output store_t st,
                               output logic ok);
    ok = (exp_q.size() != 0);
    if (!ok) begin
      other_errors++;
      $display("lane %0d delivered a store at %0t ns with none outstanding", lane, $time);
    end else begin
      st = exp_q.pop_front();
      compare_write(lane, got, st);
      delivered++;
    end
  endtask

  // producer side of the handshake plus stall bursts
  always @(negedge clk) begin
    if (cycles >= 6) begin
      rng = lcg_step(rng);
      if (stall_left != 0) begin
        st_stall   = 1'b1;
        stall_left = stall_left - 1;
      end else if (rng[31:29] == 3'd0) begin
        st_stall   = 1'b1;
        stall_left = int'(rng[28:26]);
      end else begin
        st_stall = 1'b0;
      end
      if (st_req && st_ack) begin
        exp_q.push_back(st_in);
        sent   = sent + 1;
        st_req = 1'b0;
        gap    = int'(rng[25:24]);
      end else if (!st_req && !st_ack && sent < NUM_STORES) begin
        if (gap != 0) begin
          gap = gap - 1;
        end else begin
          build_store(new_store);
          st_in  = new_store;
          st_req = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (arst_n) begin
      if (prev_stall) begin
        check_value(128'({st0_en, st0_wr}), 128'(prev_out0), "lane 0 output moved in a stall");
        check_value(128'({st1_en, st1_wr}), 128'(prev_out1), "lane 1 output moved in a stall");
      end
      check_value(128'(st1_en && !st0_en), 128'(0), "st1_en high without st0_en");
      got0 = 1'b0;
      got1 = 1'b0;
      if (!st_stall && st0_en) begin
        take_delivery(0, st0_wr, first, got0);
      end
      if (!st_stall && st1_en) begin
        take_delivery(1, st1_wr, second, got1);
      end
      if (got0 && got1) begin
        check_value(128'(bank_span(first.addr, first.size) & bank_span(second.addr, second.size)),
                    128'(0), "paired stores share a bank");
      end
      if (!prev_ack && st_ack) begin
        check_value(128'(prev_req), 128'(1), "st_ack rose with st_req low");
      end
      if (prev_ack && !st_ack) begin
        check_value(128'(prev_req), 128'(0), "st_ack fell with st_req high");
      end
      prev_stall = st_stall;
      prev_req   = st_req;
      prev_ack   = st_ack;
      prev_out0  = {st0_en, st0_wr};
      prev_out1  = {st1_en, st1_wr};
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, %0d of %0d stores delivered",
               cycles, delivered, NUM_STORES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    check_value(128'({st_ack, st0_en, st1_en}), 128'(0), "ack or enable high after reset");
    wait (delivered == NUM_STORES);
    // window for stray deliveries
    repeat (10) @(posedge clk);
    if (exp_q.size() != 0 || sent != NUM_STORES) begin
      other_errors++;
      $display("%0d stores sent, %0d never delivered", sent, exp_q.size());
    end
    $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: hw/store_drain.sv
`timescale 1ns/100ps

module store_drain import lsq_pkg::*; #(
  parameter int BUF_DEPTH = 4
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      st_req,
  output logic      st_ack,
  input  store_t    st_in,
  input  logic      st_stall,
  output cache_wr_t st0_wr,
  output logic      st0_en,
  output cache_wr_t st1_wr,
  output logic      st1_en
);

  store_t head;
  logic   head_valid;
  store_t next;
  logic   next_valid;
  logic   pop1;
  logic   pop2;
  store_t lane0_st;
  logic   lane0_en;
  store_t lane1_st;
  logic   lane1_en;

  store_buffer #(
    .BUF_DEPTH(BUF_DEPTH)
  ) u_buffer (
    .clk       (clk),
    .arst_n    (arst_n),
    .st_req    (st_req),
    .st_ack    (st_ack),
    .st_in     (st_in),
    .head      (head),
    .head_valid(head_valid),
    .next      (next),
    .next_valid(next_valid),
    .pop1      (pop1),
    .pop2      (pop2)
  );

  store_pair u_pair (
    .clk       (clk),
    .arst_n    (arst_n),
    .st_stall  (st_stall),
    .head      (head),
    .head_valid(head_valid),
    .next      (next),
    .next_valid(next_valid),
    .pop1      (pop1),
    .pop2      (pop2),
    .lane0_st  (lane0_st),
    .lane0_en  (lane0_en),
    .lane1_st  (lane1_st),
    .lane1_en  (lane1_en)
  );

  // lane 0 always carries the older store
  store_lane u_lane0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .st_stall(st_stall),
    .st      (lane0_st),
    .en      (lane0_en),
    .wr      (st0_wr),
    .wr_en   (st0_en)
  );

  store_lane u_lane1 (
    .clk     (clk),
    .arst_n  (arst_n),
    .st_stall(st_stall),
    .st      (lane1_st),
    .en      (lane1_en),
    .wr      (st1_wr),
    .wr_en   (st1_en)
  );

endmodule

// File: hw/store_lane.sv
`timescale 1ns/100ps

module store_lane import lsq_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      st_stall,
  input  store_t    st,
  input  logic      en,
  output cache_wr_t wr,
  output logic      wr_en
);

  logic [1:0] offset;
  logic [3:0] nbytes;
  // last byte relative to the start bank, up to 10
  logic [3:0] last;
  bank_t      start_bank;
  bank_t      end_bank;
  ben_t       bgn_ben;
  ben_t       end_ben;
  line_data_t line;
  cache_wr_t  wr_d;

  assign offset     = st.addr[1:0];
  assign nbytes     = 4'd1 << st.size;
  assign last       = {2'b00, offset} + nbytes - 4'd1;
  assign start_bank = st.addr[4:2];
  assign end_bank   = start_bank + bank_t'(last[3:2]);

  // begin bank covers offset up to min(last, 3)
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      bgn_ben[i] = (i >= int'(offset)) && (i <= int'(last));
    end
  end

  always_comb begin
    if (last[3:2] != 2'b00) begin
      for (int i = 0; i < 4; i++) begin
        end_ben[i] = (i <= int'(last[1:0]));
      end
    end else begin
      end_ben = bgn_ben;
    end
  end

  // data moved to its byte lane in the start bank
  assign line = line_data_t'(st.data) << {offset, 3'b000};

  always_comb begin
    wr_d.addr       = st.addr;
    wr_d.start_bank = start_bank;
    wr_d.end_bank   = end_bank;
    wr_d.bgn_ben    = bgn_ben;
    wr_d.end_ben    = end_ben;
    wr_d.data       = line;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_en <= 1'b0;
    end else if (!st_stall) begin
      wr_en <= en;
    end
  end

  always_ff @(posedge clk) begin
    if (!st_stall) begin
      wr <= wr_d;
    end
  end

endmodule

// File: hw/store_pair.sv
`timescale 1ns/100ps

module store_pair import lsq_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   st_stall,
  input  store_t head,
  input  logic   head_valid,
  input  store_t next,
  input  logic   next_valid,
  output logic   pop1,
  output logic   pop2,
  output store_t lane0_st,
  output logic   lane0_en,
  output store_t lane1_st,
  output logic   lane1_en
);

  bank_mask_t head_span;
  bank_mask_t next_span;
  logic       disjoint;
  logic       take_head;
  logic       take_next;

  assign head_span = bank_span(head.addr, head.size);
  assign next_span = bank_span(next.addr, next.size);
  assign disjoint  = ((head_span & next_span) == '0);

  // second port only when no bank is shared with the older store
  assign take_head = head_valid;
  assign take_next = head_valid && next_valid && disjoint;

  assign pop1 = take_head && !st_stall;
  assign pop2 = take_next && !st_stall;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lane0_en <= 1'b0;
      lane1_en <= 1'b0;
    end else if (!st_stall) begin
      lane0_en <= take_head;
      lane1_en <= take_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!st_stall) begin
      lane0_st <= head;
      lane1_st <= next;
    end
  end

endmodule

// File: hw/store_buffer.sv
`timescale 1ns/100ps

module store_buffer import lsq_pkg::*; #(
  parameter int BUF_DEPTH = 4
) (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   st_req,
  output logic   st_ack,
  input  store_t st_in,
  output store_t head,
  output logic   head_valid,
  output store_t next,
  output logic   next_valid,
  input  logic   pop1,
  input  logic   pop2
);

  localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  typedef enum logic {
    HS_IDLE,
    HS_ACKED
  } hs_state_t;

  hs_state_t        hs_state;
  store_t           mem [BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] nxt_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;

  // pointer step with wrap at the buffer end
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(BUF_DEPTH - 1)) begin
      return '0;
    end
    return p + PTR_W'(1);
  endfunction

  assign full       = (count == CNT_W'(BUF_DEPTH));
  assign push       = (hs_state == HS_IDLE) && st_req && !full;
  assign st_ack     = (hs_state == HS_ACKED);

  assign nxt_ptr    = ptr_inc(rd_ptr);
  assign head       = mem[rd_ptr];
  assign next       = mem[nxt_ptr];
  assign head_valid = (count != '0);
  assign next_valid = (count > CNT_W'(1));

  // four-phase receiver
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hs_state <= HS_IDLE;
    end else begin
      case (hs_state)
        HS_IDLE: begin
          if (push) begin
            hs_state <= HS_ACKED;
          end
        end
        HS_ACKED: begin
          if (!st_req) begin
            hs_state <= HS_IDLE;
          end
        end
        default: hs_state <= HS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      // pop2 only comes with pop1
      if (pop2) begin
        rd_ptr <= ptr_inc(nxt_ptr);
      end else if (pop1) begin
        rd_ptr <= nxt_ptr;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop1) - CNT_W'(pop2);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= st_in;
    end
  end

endmodule

// File: hw/lsq_pkg.sv
package lsq_pkg;

  // byte address, [1:0] offset in bank, [4:2] start bank
  typedef logic [11:0] addr_t;
  typedef logic [2:0]  bank_t;
  typedef logic [7:0]  bank_mask_t;
  typedef logic [3:0]  ben_t;
  // log2 of the byte count
  typedef logic [1:0]  size_t;
  typedef logic [63:0] sdata_t;
  // three consecutive 4 byte banks
  typedef logic [95:0] line_data_t;

  typedef struct packed {
    addr_t  addr;
    size_t  size;
    sdata_t data;
  } store_t;

  typedef struct packed {
    addr_t      addr;
    bank_t      start_bank;
    bank_t      end_bank;
    ben_t       bgn_ben;
    ben_t       end_ben;
    line_data_t data;
  } cache_wr_t;

  // banks touched by a store, start through end, wrapping past bank 7
  function automatic bank_mask_t bank_span(input addr_t addr, input size_t size);
    logic [3:0] last;
    bank_mask_t mask;
    bank_t      bank;
    last = {2'b00, addr[1:0]} + (4'd1 << size) - 4'd1;
    mask = '0;
    bank = addr[4:2];
    for (int i = 0; i < 3; i++) begin
      if (i <= int'(last[3:2])) begin
        mask[bank] = 1'b1;
      end
      bank = bank + 3'd1;
    end
    return mask;
  endfunction

endpackage
